//--- disagg_pkg.sv
// Shared sizes and packed types for the packet disaggregator
// Input beats are 32 bits wide, outputs are 8 bits, one page per output
// Packets longer than MAX_PKT_BYTES are cut at the page boundary
`default_nettype none

package disagg_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    // Input byte width over output byte width
    localparam int NUM_COLS      = 4;
    localparam int NUM_OUTPUTS   = 4;
    localparam int IN_BYTES      = 4;
    // Rows per page, one page per output
    localparam int PAGE_DEPTH    = 4;
    localparam int MAX_PKT_BYTES = 16;
    localparam int REPORT_DEPTH  = 16;
    localparam int OUT_BUF_DEPTH = 2;

    // ------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------
    typedef logic [$clog2(NUM_OUTPUTS)-1:0]     ctxt_t;
    typedef logic [$clog2(PAGE_DEPTH)-1:0]      row_t;
    typedef logic [$clog2(NUM_COLS)-1:0]        col_t;
    // Holds 0 up to MAX_PKT_BYTES inclusive
    typedef logic [$clog2(MAX_PKT_BYTES+1)-1:0] size_t;

    // ------------------------------------------------------------
    // Beats and requests
    // ------------------------------------------------------------
    // Byte 0 sits in bits 7:0 and leaves first
    typedef struct packed {
        logic [IN_BYTES*8-1:0]       data;
        logic                        eop;
        logic [$clog2(IN_BYTES)-1:0] last_bytes;
    } in_beat_t;

    typedef struct packed {
        logic [7:0] data;
        logic       eop;
    } out_beat_t;

    typedef struct packed {
        size_t size;
    } desc_t;

    // Same row in every column, column c takes byte lane c
    typedef struct packed {
        ctxt_t                 ctxt;
        row_t                  row;
        logic [IN_BYTES*8-1:0] data;
    } wr_req_t;

    typedef struct packed {
        row_t row;
        col_t col;
    } rd_req_t;

endpackage

`default_nettype wire

//--- sync_fifo.sv
// Small synchronous FIFO with a registered occupancy count
// DEPTH must be 2 or more; a push while full is ignored
// Head entry is visible on pop_data whenever pop_valid is high
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        push,
    input  payload_t    push_data,
    input  logic        pop,
    output logic        pop_valid,
    output payload_t    pop_data,
    output logic        full,
    output logic [31:0] count
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic                       do_push;
    logic                       do_pop;

    assign pop_valid = (count != 32'd0);
    assign full      = (count == 32'(DEPTH));
    assign pop_data  = mem[rd_ptr];

    assign do_push = push && !full;
    assign do_pop  = pop && pop_valid;

    // Storage
    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH-1
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 32'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 32'd1;
                2'b01:   count <= count - 32'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pkt_ingest.sv
// Decode stage: accepts wide beats and writes them into the page of in_ctxt
// in_ctxt must hold steady for all beats of a packet
// Packets to different contexts may not interleave at beat level
// Beats past the page are dropped and the size saturates at MAX_PKT_BYTES
`timescale 1ns/1ps
`default_nettype none

module pkt_ingest (
    input  logic                                 clk_in,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  disagg_pkg::in_beat_t                 in_beat,
    input  disagg_pkg::ctxt_t                    in_ctxt,
    input  logic                                 rpt_full,
    input  logic [disagg_pkg::NUM_OUTPUTS-1:0]   done,
    output logic                                 in_ready,
    output logic                                 wr_en,
    output disagg_pkg::wr_req_t                  wr_req,
    output logic [disagg_pkg::NUM_OUTPUTS-1:0]   desc_valid,
    output disagg_pkg::desc_t                    desc,
    output logic                                 rpt_push,
    output disagg_pkg::ctxt_t                    rpt_ctxt
);

    // Row count runs one past the page to flag overflow
    logic [$clog2(disagg_pkg::PAGE_DEPTH+1)-1:0] row_cnt;
    disagg_pkg::size_t                           byte_cnt;
    logic [disagg_pkg::NUM_OUTPUTS-1:0]          busy;
    logic                                        accept;
    logic                                        last_beat;
    logic                                        page_open;
    logic [$bits(disagg_pkg::size_t):0]          size_sum;
    disagg_pkg::size_t                           pkt_size;

    // ------------------------------------------------------------
    // Handshake and page write
    // ------------------------------------------------------------
    assign in_ready  = !busy[in_ctxt] && !rpt_full;
    assign accept    = in_valid && in_ready;
    assign last_beat = accept && in_beat.eop;
    assign page_open = (row_cnt < disagg_pkg::PAGE_DEPTH);

    assign wr_en = accept && page_open;

    always_comb begin
        wr_req.ctxt = in_ctxt;
        wr_req.row  = disagg_pkg::row_t'(row_cnt);
        wr_req.data = in_beat.data;
    end

    // Bytes of full rows so far plus the bytes of the eop beat
    always_comb begin
        size_sum = {1'b0, byte_cnt} + {1'b0, 3'(in_beat.last_bytes)} + 1'b1;
        if (size_sum > disagg_pkg::MAX_PKT_BYTES) begin
            pkt_size = disagg_pkg::size_t'(disagg_pkg::MAX_PKT_BYTES);
        end else begin
            pkt_size = disagg_pkg::size_t'(size_sum);
        end
    end

    // ------------------------------------------------------------
    // Descriptor and report, both on the eop beat
    // ------------------------------------------------------------
    always_comb begin
        for (int g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin
            desc_valid[g] = last_beat && (in_ctxt == disagg_pkg::ctxt_t'(g));
        end
    end

    assign desc.size = pkt_size;
    assign rpt_push  = last_beat;
    assign rpt_ctxt  = in_ctxt;

    // Counters restart after every eop
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            row_cnt  <= '0;
            byte_cnt <= '0;
        end else if (last_beat) begin
            row_cnt  <= '0;
            byte_cnt <= '0;
        end else if (accept && page_open) begin
            row_cnt  <= row_cnt + 1'b1;
            byte_cnt <= byte_cnt + disagg_pkg::size_t'(disagg_pkg::IN_BYTES);
        end
    end

    // Page stays busy from descriptor until egress reports done
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            for (int g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin
                if (desc_valid[g]) begin
                    busy[g] <= 1'b1;
                end else if (done[g]) begin
                    busy[g] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- column_bank.sv
// Execute stage: four byte-wide column RAMs with a rotating read slot
// Output g owns column (sel + g) mod NUM_COLS in each cycle
// Reads are granted in the same cycle, data returns one cycle later
`timescale 1ns/1ps
`default_nettype none

module column_bank (
    input  logic                               clk_in,
    input  logic                               rst_n,
    input  logic                               wr_en,
    input  disagg_pkg::wr_req_t                wr_req,
    input  logic [disagg_pkg::NUM_OUTPUTS-1:0] rd_valid,
    input  disagg_pkg::rd_req_t                rd_req [disagg_pkg::NUM_OUTPUTS],
    output logic [disagg_pkg::NUM_OUTPUTS-1:0] rd_gnt,
    output logic [disagg_pkg::NUM_OUTPUTS-1:0] rd_data_valid,
    output logic [7:0]                         rd_data [disagg_pkg::NUM_OUTPUTS]
);

    disagg_pkg::col_t sel;
    // Slot of the previous cycle, steers returning data
    disagg_pkg::col_t sel_d;
    logic [7:0]       col_q [disagg_pkg::NUM_COLS];

    // ------------------------------------------------------------
    // Rotator
    // ------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            sel   <= '0;
            sel_d <= '0;
        end else begin
            sel   <= sel + 1'b1;
            sel_d <= sel;
        end
    end

    // ------------------------------------------------------------
    // Per output grant and return
    // ------------------------------------------------------------
    for (genvar g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin : g_out
        assign rd_gnt[g] = rd_valid[g] &&
            (rd_req[g].col == disagg_pkg::col_t'(sel + disagg_pkg::col_t'(g)));
        assign rd_data[g] = col_q[disagg_pkg::col_t'(sel_d + disagg_pkg::col_t'(g))];
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rd_data_valid <= '0;
        end else begin
            rd_data_valid <= rd_gnt;
        end
    end

    // ------------------------------------------------------------
    // Column memories
    // ------------------------------------------------------------
    for (genvar c = 0; c < disagg_pkg::NUM_COLS; c++) begin : g_col
        logic [7:0] ram [disagg_pkg::NUM_OUTPUTS * disagg_pkg::PAGE_DEPTH];
        // Output whose slot this column is
        disagg_pkg::ctxt_t srv;
        logic [$bits(disagg_pkg::ctxt_t)+$bits(disagg_pkg::row_t)-1:0] rd_addr;

        assign srv     = disagg_pkg::ctxt_t'(disagg_pkg::col_t'(c) - sel);
        assign rd_addr = {srv, rd_req[srv].row};

        // Page is selected by context, row within the page by wr_req.row
        always_ff @(posedge clk_in) begin
            if (wr_en) begin
                ram[{wr_req.ctxt, wr_req.row}] <= wr_req.data[c*8 +: 8];
            end
        end

        always_ff @(posedge clk_in) begin
            if (rd_gnt[srv]) begin
                col_q[c] <= ram[rd_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- pkt_egress.sv
// Result stage: reads one packet byte by byte and emits narrow beats
// Expects no new descriptor while a packet is still being drained
// Reads are throttled so buffered plus in-flight bytes fit the buffer
`timescale 1ns/1ps
`default_nettype none

module pkt_egress (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic                   desc_valid,
    input  disagg_pkg::desc_t      desc,
    input  logic                   rd_gnt,
    input  logic                   rd_data_valid,
    input  logic [7:0]             rd_data,
    input  logic                   out_ready,
    output logic                   done,
    output logic                   rd_valid,
    output disagg_pkg::rd_req_t    rd_req,
    output logic                   out_valid,
    output disagg_pkg::out_beat_t  out_beat
);

    logic                  active;
    disagg_pkg::size_t     byte_idx;
    disagg_pkg::size_t     size;
    logic                  inflight;
    logic                  inflight_eop;
    logic                  out_pop;
    logic                  room;
    logic [31:0]           buf_count;
    disagg_pkg::out_beat_t ret_beat;

    // ------------------------------------------------------------
    // Read request
    // ------------------------------------------------------------
    // Byte b lives in row b / IN_BYTES, column b mod NUM_COLS
    always_comb begin
        rd_req.row = disagg_pkg::row_t'(byte_idx / disagg_pkg::IN_BYTES);
        rd_req.col = disagg_pkg::col_t'(byte_idx % disagg_pkg::NUM_COLS);
    end

    assign out_pop = out_valid && out_ready;

    // A pop in this cycle frees a slot for the read issued now
    assign room = (buf_count + {31'd0, inflight}) <
                  (32'(disagg_pkg::OUT_BUF_DEPTH) + {31'd0, out_pop});

    assign rd_valid = active && (byte_idx < size) && room;

    // ------------------------------------------------------------
    // Packet state
    // ------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            active       <= 1'b0;
            byte_idx     <= '0;
            inflight     <= 1'b0;
            inflight_eop <= 1'b0;
        end else begin
            inflight <= rd_gnt;
            if (rd_gnt) begin
                byte_idx     <= byte_idx + 1'b1;
                inflight_eop <= (byte_idx + 1'b1 == size);
            end
            if (desc_valid) begin
                active   <= 1'b1;
                byte_idx <= '0;
            end else if (done) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (desc_valid) begin
            size <= desc.size;
        end
    end

    // ------------------------------------------------------------
    // Output buffer
    // ------------------------------------------------------------
    always_comb begin
        ret_beat.data = rd_data;
        ret_beat.eop  = inflight_eop;
    end

    sync_fifo #(
        .payload_t ( disagg_pkg::out_beat_t ),
        .DEPTH     ( disagg_pkg::OUT_BUF_DEPTH )
    ) i_out_buf (
        .clk_in    ( clk_in ),
        .rst_n     ( rst_n ),
        .push      ( rd_data_valid ),
        .push_data ( ret_beat ),
        .pop       ( out_ready ),
        .pop_valid ( out_valid ),
        .pop_data  ( out_beat ),
        .full      ( ),
        .count     ( buf_count )
    );

    // Last byte has left, page can be reused
    assign done = out_pop && out_beat.eop;

endmodule

`default_nettype wire

//--- packet_disaggregate.sv
// Top level: one 32-bit packet stream in, four 8-bit streams out
// in_ctxt selects the output and must hold for a whole packet
// A second packet to a busy output waits until the first has drained
// Report queue lists contexts in the order packets were accepted
`timescale 1ns/1ps
`default_nettype none

module packet_disaggregate (
    input  logic                               clk_in,
    input  logic                               rst_n,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  disagg_pkg::in_beat_t               in_beat,
    input  disagg_pkg::ctxt_t                  in_ctxt,
    output logic [disagg_pkg::NUM_OUTPUTS-1:0] out_valid,
    input  logic [disagg_pkg::NUM_OUTPUTS-1:0] out_ready,
    output disagg_pkg::out_beat_t              out_beat [disagg_pkg::NUM_OUTPUTS],
    output logic                               ctxt_out_valid,
    output disagg_pkg::ctxt_t                  ctxt_out,
    input  logic                               ctxt_out_ack
);

    logic                               wr_en;
    disagg_pkg::wr_req_t                wr_req;
    logic [disagg_pkg::NUM_OUTPUTS-1:0] desc_valid;
    disagg_pkg::desc_t                  desc;
    logic [disagg_pkg::NUM_OUTPUTS-1:0] done;
    logic [disagg_pkg::NUM_OUTPUTS-1:0] rd_valid;
    disagg_pkg::rd_req_t                rd_req [disagg_pkg::NUM_OUTPUTS];
    logic [disagg_pkg::NUM_OUTPUTS-1:0] rd_gnt;
    logic [disagg_pkg::NUM_OUTPUTS-1:0] rd_data_valid;
    logic [7:0]                         rd_data [disagg_pkg::NUM_OUTPUTS];
    logic                               rpt_push;
    disagg_pkg::ctxt_t                  rpt_ctxt;
    logic                               rpt_full;

    pkt_ingest i_pkt_ingest (
        .clk_in, .rst_n, .in_valid, .in_beat, .in_ctxt, .rpt_full, .done,
        .in_ready, .wr_en, .wr_req, .desc_valid, .desc, .rpt_push, .rpt_ctxt
    );

    column_bank i_column_bank (
        .clk_in, .rst_n, .wr_en, .wr_req, .rd_valid, .rd_req,
        .rd_gnt, .rd_data_valid, .rd_data
    );

    // One reader per output page
    for (genvar g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin : g_egress
        pkt_egress i_pkt_egress (
            .clk_in        ( clk_in ),
            .rst_n         ( rst_n ),
            .desc_valid    ( desc_valid[g] ),
            .desc          ( desc ),
            .rd_gnt        ( rd_gnt[g] ),
            .rd_data_valid ( rd_data_valid[g] ),
            .rd_data       ( rd_data[g] ),
            .out_ready     ( out_ready[g] ),
            .done          ( done[g] ),
            .rd_valid      ( rd_valid[g] ),
            .rd_req        ( rd_req[g] ),
            .out_valid     ( out_valid[g] ),
            .out_beat      ( out_beat[g] )
        );
    end

    // Context report queue
    sync_fifo #(
        .payload_t ( disagg_pkg::ctxt_t ),
        .DEPTH     ( disagg_pkg::REPORT_DEPTH )
    ) i_report_fifo (
        .clk_in    ( clk_in ),
        .rst_n     ( rst_n ),
        .push      ( rpt_push ),
        .push_data ( rpt_ctxt ),
        .pop       ( ctxt_out_ack ),
        .pop_valid ( ctxt_out_valid ),
        .pop_data  ( ctxt_out ),
        .full      ( rpt_full ),
        .count     ( )
    );

endmodule

`default_nettype wire

//--- tb_packet_disaggregate.sv
// Self-checking testbench for the packet disaggregator
// Packets come from a table, byte contents from $urandom with a fixed seed
// Expected bytes and report entries are queued when the DUT accepts a beat
// A watchdog scaled to the number of packets bounds the run
`timescale 1ns/1ps
`default_nettype none

module tb_packet_disaggregate;

    typedef struct packed {
        disagg_pkg::ctxt_t ctxt;
        logic [4:0]        len;
        logic [6:0]        duty;
        logic              drain;
    } entry_t;

    localparam int NUM_ENTRIES  = 28;
    // Report phase sends one packet more than the queue holds
    localparam int FILL_PKTS    = disagg_pkg::REPORT_DEPTH + 1;
    localparam int LIMIT_CYCLES = 200 * (NUM_ENTRIES + FILL_PKTS) + 1000;

    // Context, length in bytes, out_ready percent, drain afterwards
    localparam entry_t PKT_TABLE [NUM_ENTRIES] = '{
        '{2'd0, 5'd1, 7'd100, 1'b1},  '{2'd1, 5'd2, 7'd100, 1'b1},
        '{2'd2, 5'd3, 7'd100, 1'b1},  '{2'd3, 5'd4, 7'd100, 1'b1},
        '{2'd0, 5'd5, 7'd100, 1'b1},  '{2'd1, 5'd6, 7'd100, 1'b1},
        '{2'd2, 5'd7, 7'd100, 1'b1},  '{2'd3, 5'd8, 7'd100, 1'b1},
        '{2'd0, 5'd9, 7'd100, 1'b1},  '{2'd1, 5'd10, 7'd100, 1'b1},
        '{2'd2, 5'd11, 7'd100, 1'b1}, '{2'd3, 5'd12, 7'd100, 1'b1},
        '{2'd0, 5'd13, 7'd100, 1'b1}, '{2'd1, 5'd14, 7'd100, 1'b1},
        '{2'd2, 5'd15, 7'd100, 1'b1}, '{2'd3, 5'd16, 7'd100, 1'b1},
        // All four outputs back to back
        '{2'd0, 5'd16, 7'd100, 1'b0}, '{2'd1, 5'd16, 7'd100, 1'b0},
        '{2'd2, 5'd16, 7'd100, 1'b0}, '{2'd3, 5'd16, 7'd100, 1'b1},
        // Same output twice
        '{2'd2, 5'd13, 7'd100, 1'b0}, '{2'd2, 5'd7, 7'd100, 1'b1},
        // Random back-pressure
        '{2'd1, 5'd16, 7'd40, 1'b0},  '{2'd3, 5'd11, 7'd40, 1'b0},
        '{2'd0, 5'd6, 7'd25, 1'b0},   '{2'd1, 5'd9, 7'd60, 1'b0},
        '{2'd2, 5'd16, 7'd25, 1'b0},  '{2'd1, 5'd3, 7'd50, 1'b1}
    };

    logic                               clk_in;
    logic                               rst_n;
    logic                               in_valid;
    logic                               in_ready;
    disagg_pkg::in_beat_t               in_beat;
    disagg_pkg::ctxt_t                  in_ctxt;
    logic [disagg_pkg::NUM_OUTPUTS-1:0] out_valid;
    logic [disagg_pkg::NUM_OUTPUTS-1:0] out_ready;
    disagg_pkg::out_beat_t              out_beat [disagg_pkg::NUM_OUTPUTS];
    logic                               ctxt_out_valid;
    disagg_pkg::ctxt_t                  ctxt_out;
    logic                               ctxt_out_ack;

    disagg_pkg::out_beat_t exp_q [disagg_pkg::NUM_OUTPUTS][$];
    disagg_pkg::ctxt_t     exp_rpt [$];
    int                    errors          = 0;
    int                    checks          = 0;
    int                    duty            = 100;
    logic                  hold_ack        = 1'b0;
    logic                  seen_concurrent = 1'b0;

    packet_disaggregate i_packet_disaggregate (
        .clk_in, .rst_n, .in_valid, .in_ready, .in_beat, .in_ctxt,
        .out_valid, .out_ready, .out_beat, .ctxt_out_valid, .ctxt_out, .ctxt_out_ack
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_beat(input disagg_pkg::out_beat_t got,
                              input disagg_pkg::out_beat_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t: %s data %02h eop %0b, expected data %02h eop %0b",
                     $time, what, got.data, got.eop, exp.data, exp.eop);
            errors++;
        end
    endtask

    task automatic check_ctxt(input disagg_pkg::ctxt_t got, input disagg_pkg::ctxt_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t: report context %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic compare_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_counts();
        $display("Checks: %0d compared, %0d errors", checks, errors);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    // Entered and left 1 ns after a rising edge
    task automatic send_packet(input disagg_pkg::ctxt_t ctxt, input int len);
        int                    nbeats;
        int                    idx;
        disagg_pkg::in_beat_t  beat;
        disagg_pkg::out_beat_t exp_beat;
        nbeats = (len + disagg_pkg::IN_BYTES - 1) / disagg_pkg::IN_BYTES;
        for (int b = 0; b < nbeats; b++) begin
            // Unused lanes of the last beat carry filler
            beat.data       = $urandom;
            beat.eop        = (b == nbeats - 1);
            beat.last_bytes = 2'((len - 1) % disagg_pkg::IN_BYTES);
            in_valid = 1'b1;
            in_beat  = beat;
            in_ctxt  = ctxt;
            do begin
                @(posedge clk_in);
            end while (!in_ready);
            // Page must have drained before a new packet is taken
            if (b == 0 && exp_q[ctxt].size() != 0) begin
                $display("Early accept at %0t: output %0d still had %0d bytes pending",
                         $time, ctxt, exp_q[ctxt].size());
                errors++;
            end
            for (int k = 0; k < disagg_pkg::IN_BYTES; k++) begin
                idx = b * disagg_pkg::IN_BYTES + k;
                if (idx < len) begin
                    exp_beat.data = beat.data[k*8 +: 8];
                    exp_beat.eop  = (idx == len - 1);
                    exp_q[ctxt].push_back(exp_beat);
                end
            end
            if (beat.eop) begin
                exp_rpt.push_back(ctxt);
            end
            #1;
        end
        in_valid = 1'b0;
    endtask

    // Queues are looked at 1 ns after the edge, once the monitor has popped
    task automatic wait_for_drain(input logic with_report);
        int pending;
        do begin
            @(posedge clk_in);
            #1;
            pending = with_report ? exp_rpt.size() : 0;
            for (int g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin
                pending = pending + exp_q[g].size();
            end
        end while (pending != 0);
    endtask

    // Back-pressure and report ack, settings taken at the edge
    initial begin : sink_driver
        int   level;
        logic hold;
        out_ready    = '0;
        ctxt_out_ack = 1'b0;
        forever begin
            @(posedge clk_in);
            level = duty;
            hold  = hold_ack;
            #1;
            for (int g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin
                out_ready[g] = ($urandom_range(99) < level);
            end
            ctxt_out_ack = !hold;
        end
    end

    // ------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------
    initial begin : monitor
        disagg_pkg::out_beat_t exp_beat;
        disagg_pkg::ctxt_t     exp_ctxt;
        forever begin
            @(posedge clk_in);
            if (rst_n) begin
                if ($countones(out_valid) > 1) begin
                    seen_concurrent = 1'b1;
                end
                for (int g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin
                    if (out_valid[g] && out_ready[g]) begin
                        if (exp_q[g].size() == 0) begin
                            $display("Unexpected beat at %0t: output %0d sent %02h",
                                     $time, g, out_beat[g].data);
                            errors++;
                        end else begin
                            exp_beat = exp_q[g].pop_front();
                            check_beat(out_beat[g], exp_beat, $sformatf("output %0d", g));
                        end
                    end
                end
                if (ctxt_out_valid && ctxt_out_ack) begin
                    if (exp_rpt.size() == 0) begin
                        $display("Unexpected report at %0t: context %0d", $time, ctxt_out);
                        errors++;
                    end else begin
                        exp_ctxt = exp_rpt.pop_front();
                        check_ctxt(ctxt_out, exp_ctxt);
                    end
                end
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk_in);
        $display("Timeout: run did not complete within %0d cycles", LIMIT_CYCLES);
        report_counts();
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : main
        void'($urandom(32'he6fa_da97));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        in_ctxt  = '0;
        repeat (10) @(posedge clk_in);
        #1;
        rst_n = 1'b1;
        @(posedge clk_in);
        compare_level(|out_valid, 1'b0, "out_valid after reset");
        compare_level(ctxt_out_valid, 1'b0, "ctxt_out_valid after reset");
        compare_level(in_ready, 1'b1, "in_ready after reset");
        #1;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            duty = int'(PKT_TABLE[i].duty);
            send_packet(PKT_TABLE[i].ctxt, int'(PKT_TABLE[i].len));
            if (PKT_TABLE[i].drain) begin
                wait_for_drain(1'b1);
            end
        end

        // Fill the report queue with ack held low
        duty     = 100;
        hold_ack = 1'b1;
        for (int i = 0; i < disagg_pkg::REPORT_DEPTH; i++) begin
            send_packet(disagg_pkg::ctxt_t'(i % disagg_pkg::NUM_OUTPUTS), (i % 5) + 1);
        end
        wait_for_drain(1'b0);
        in_valid       = 1'b1;
        in_ctxt        = '0;
        in_beat        = '0;
        in_beat.eop    = 1'b1;
        repeat (8) begin
            @(posedge clk_in);
            compare_level(in_ready, 1'b0, "in_ready with report queue full");
        end
        #1;
        in_valid = 1'b0;
        hold_ack = 1'b0;
        send_packet(2'd0, 12);
        wait_for_drain(1'b1);
        repeat (5) @(posedge clk_in);

        for (int g = 0; g < disagg_pkg::NUM_OUTPUTS; g++) begin
            if (exp_q[g].size() != 0) begin
                $display("Missing output: %0d bytes never left output %0d", exp_q[g].size(), g);
                errors++;
            end
        end
        if (exp_rpt.size() != 0) begin
            $display("Missing report: %0d contexts never reported", exp_rpt.size());
            errors++;
        end
        if (!seen_concurrent) begin
            $display("No overlap: outputs never streamed at the same time");
            errors++;
        end
        report_counts();
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- packet_disaggregate.f
disagg_pkg.sv
sync_fifo.sv
pkt_ingest.sv
column_bank.sv
pkt_egress.sv
packet_disaggregate.sv
tb_packet_disaggregate.sv

//--- Makefile
# Verilator flow for the packet disaggregator
RTL := disagg_pkg.sv sync_fifo.sv pkt_ingest.sv column_bank.sv pkt_egress.sv \
       packet_disaggregate.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module packet_disaggregate $(RTL)

sim:
	verilator --binary --timing --top-module tb_packet_disaggregate \
		-Mdir obj_dir -f packet_disaggregate.f
	-./obj_dir/Vtb_packet_disaggregate > sim.log 2>&1
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
